// File: list.f
+incdir+logic
logic/sopc_pkg.sv
logic/wb_if.sv
logic/bus_decoder.sv
logic/ram_slave.sv
logic/segdisp_slave.sv
logic/timer_slave.sv
logic/mini_sopc.sv
sim/tb_clock.sv
sim/tb_mini_sopc.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the testbench, exit status is the simulator's
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f list.f \
	--top-module tb_mini_sopc \
	-o tb_mini_sopc

./obj_dir/tb_mini_sopc

// File: sim/tb_mini_sopc.sv
`include "sopc_cfg.svh"

module tb_mini_sopc;

	timeunit 1ns;
	timeprecision 1ps;

	logic                  clk;
	logic                  arst_n;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic [`SOPC_SELW-1:0] wb_sel;
	logic [`SOPC_AW-1:0]   wb_adr;
	logic [`SOPC_DW-1:0]   wb_dat_w;
	logic [`SOPC_DW-1:0]   wb_dat_r;
	logic                  wb_ack;
	logic [6:0]            seg0;
	logic [6:0]            seg1;
	logic                  tmr_int;

	// reference state
	logic [`SOPC_DW-1:0]   shadow_ram [0:`RAM_WORDS-1];
	logic [7:0]            shadow_disp;
	logic [7:0]            used_idx [$];

	int                    seed;
	int                    waited;
	logic [`SOPC_DW-1:0]   data;
	logic [`SOPC_DW-1:0]   rdata;
	logic [3:0]            sel_v;
	logic [7:0]            idx_v;
	logic [`SOPC_AW-1:0]   none_adr;

	tb_clock clk_gen (
		.clk_o    (clk),
		.arst_n_o (arst_n)
	);

	mini_sopc DUT (
		.clk         (clk),
		.arst_n_i    (arst_n),
		.wb_cyc_i    (wb_cyc),
		.wb_stb_i    (wb_stb),
		.wb_we_i     (wb_we),
		.wb_sel_i    (wb_sel),
		.wb_adr_i    (wb_adr),
		.wb_dat_i    (wb_dat_w),
		.wb_dat_o    (wb_dat_r),
		.wb_ack_o    (wb_ack),
		.segdisp0_o  (seg0),
		.segdisp1_o  (seg1),
		.timer_int_o (tmr_int)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			stop_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
		end
	endtask

	function automatic logic [31:0] ram_addr(input logic [7:0] idx);
		return {16'h0000, `REGION_RAM, 2'b00, idx, 2'b00};
	endfunction

	function automatic logic [31:0] tmr_addr(input sopc_pkg::tmr_reg_e r);
		return {16'h0000, `REGION_TMR, 8'h00, r, 2'b00};
	endfunction

	// segments abcdefg, a in bit 6
	function automatic logic [6:0] expect_seg(input logic [3:0] nib);
		logic [6:0] table_v [16];
		table_v = '{7'b1111110, 7'b0110000, 7'b1101101, 7'b1111001,
		            7'b0110011, 7'b1011011, 7'b1011111, 7'b1110000,
		            7'b1111111, 7'b1111011, 7'b1110111, 7'b0011111,
		            7'b1001110, 7'b0111101, 7'b1001111, 7'b1000111};
		return table_v[nib];
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	function automatic logic [31:0] expect_read(input logic [31:0] adr);
		case (adr[15:12])
			`REGION_RAM: return shadow_ram[adr[9:2]];
			`REGION_SEG: return (adr[3:2] == 2'd0) ? {24'h000000, shadow_disp} : 32'h0;
			default:     return 32'h0;
		endcase
	endfunction

	// request on a falling edge, hold through the ack edge, then drop
	task automatic bus_access(input logic we, input logic [31:0] adr,
		input logic [31:0] wdata, input logic [3:0] sel, output logic [31:0] rd);
		int cnt;
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_sel   = sel;
		wb_adr   = adr;
		wb_dat_w = wdata;
		cnt = 0;
		@(negedge clk);
		while (wb_ack !== 1'b1) begin
			cnt++;
			if (cnt >= 20) begin
				stop_run($sformatf("no ack within 20 cycles for address %h", adr));
			end
			@(negedge clk);
		end
		rd = wb_dat_r;
		@(negedge clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] adr, input logic [31:0] wdata,
		input logic [3:0] sel);
		logic [31:0] unused;
		bus_access(1'b1, adr, wdata, sel, unused);
	endtask

	task automatic bus_read(input logic [31:0] adr, output logic [31:0] rd);
		bus_access(1'b0, adr, 32'h0, 4'hf, rd);
	endtask

	initial begin
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_sel      = 4'h0;
		wb_adr      = 32'h0;
		wb_dat_w    = 32'h0;
		shadow_disp = 8'h00;
		seed        = 32'h28ce;

		waited = 0;
		while (arst_n !== 1'b1) begin
			waited++;
			if (waited > 10) begin
				stop_run("reset was never released");
			end
			@(negedge clk);
		end
		@(negedge clk);

		check_eq("reset_ack", 32'h0, 32'(wb_ack));
		check_eq("reset_int", 32'h0, 32'(tmr_int));
		check_eq("reset_seg0", 32'h0, 32'(seg0));
		check_eq("reset_seg1", 32'h0, 32'(seg1));

		// full words
		for (int i = 0; i < 40; i++) begin
			idx_v = 8'($random(seed));
			data  = $random(seed);
			bus_write(ram_addr(idx_v), data, 4'hf);
			shadow_ram[idx_v] = data;
			used_idx.push_back(idx_v);
		end
		foreach (used_idx[i]) begin
			bus_read(ram_addr(used_idx[i]), rdata);
			check_eq("ram_word", expect_read(ram_addr(used_idx[i])), rdata);
		end

		// partial writes over words already known
		for (int i = 0; i < 20; i++) begin
			idx_v = used_idx[(i * 7) % used_idx.size()];
			sel_v = 4'($random(seed));
			data  = $random(seed);
			bus_write(ram_addr(idx_v), data, sel_v);
			shadow_ram[idx_v] = merge_bytes(shadow_ram[idx_v], data, sel_v);
			bus_read(ram_addr(idx_v), rdata);
			check_eq("ram_bytes", expect_read(ram_addr(idx_v)), rdata);
		end

		for (int i = 0; i < 4; i++) begin
			shadow_disp = 8'($random(seed));
			bus_write({16'h0000, `REGION_SEG, 12'h000}, {24'h000000, shadow_disp}, 4'h1);
			check_eq("seg_low", 32'(expect_seg(shadow_disp[3:0])), 32'(seg0));
			check_eq("seg_high", 32'(expect_seg(shadow_disp[7:4])), 32'(seg1));
			bus_read({16'h0000, `REGION_SEG, 12'h000}, rdata);
			check_eq("seg_read", expect_read({16'h0000, `REGION_SEG, 12'h000}), rdata);
		end

		bus_write(tmr_addr(sopc_pkg::TMR_CMP), 32'd30, 4'hf);
		bus_write(tmr_addr(sopc_pkg::TMR_CTRL), 32'd1, 4'hf);
		waited = 0;
		while (tmr_int !== 1'b1) begin
			waited++;
			if (waited > 100) begin
				stop_run("timer interrupt did not rise within 100 cycles");
			end
			@(negedge clk);
		end
		bus_read(tmr_addr(sopc_pkg::TMR_STAT), rdata);
		check_eq("tmr_stat", 32'd1, rdata);
		bus_write(tmr_addr(sopc_pkg::TMR_STAT), 32'd1, 4'hf);
		check_eq("tmr_int_clear", 32'h0, 32'(tmr_int));
		bus_read(tmr_addr(sopc_pkg::TMR_CNT), rdata);
		if (rdata > 32'd30) begin
			stop_run($sformatf("MISMATCH tmr_cnt expected at most %0d actual %0d", 30, rdata));
		end

		// region 5 maps to nothing, low bits alias a known ram word
		none_adr = {16'h0000, 4'd5, 2'b00, used_idx[0], 2'b00};
		bus_write(none_adr, $random(seed), 4'hf);
		bus_read(none_adr, rdata);
		check_eq("unmapped_read", expect_read(none_adr), rdata);
		foreach (used_idx[i]) begin
			bus_read(ram_addr(used_idx[i]), rdata);
			check_eq("ram_after_unmapped", expect_read(ram_addr(used_idx[i])), rdata);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: sim/tb_clock.sv
module tb_clock (
	output logic clk_o,
	output logic arst_n_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// 100 ns period
	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o;
	end

	// low for four cycles, released on a falling edge
	initial begin
		arst_n_o = 1'b0;
		repeat (4) @(posedge clk_o);
		@(negedge clk_o);
		arst_n_o = 1'b1;
	end

endmodule

// File: logic/mini_sopc.sv
`include "sopc_cfg.svh"

module mini_sopc (
	input  logic                   clk,
	input  logic                   arst_n_i,

	// master side, driven by the testbench
	input  logic                   wb_cyc_i,
	input  logic                   wb_stb_i,
	input  logic                   wb_we_i,
	input  logic [`SOPC_SELW-1:0]  wb_sel_i,
	input  logic [`SOPC_AW-1:0]    wb_adr_i,
	input  logic [`SOPC_DW-1:0]    wb_dat_i,
	output logic [`SOPC_DW-1:0]    wb_dat_o,
	output logic                   wb_ack_o,

	output logic [6:0]             segdisp0_o,
	output logic [6:0]             segdisp1_o,
	output logic                   timer_int_o
);

	wb_if ram_bus ();
	wb_if seg_bus ();
	wb_if tmr_bus ();

	bus_decoder bus0 (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.cyc_i    (wb_cyc_i),
		.stb_i    (wb_stb_i),
		.we_i     (wb_we_i),
		.sel_i    (wb_sel_i),
		.adr_i    (wb_adr_i),
		.dat_w_i  (wb_dat_i),
		.dat_r_o  (wb_dat_o),
		.ack_o    (wb_ack_o),
		.ram_bus  (ram_bus.mst),
		.seg_bus  (seg_bus.mst),
		.tmr_bus  (tmr_bus.mst)
	);

	ram_slave ram0 (
		.clk (clk),
		.bus (ram_bus.slv)
	);

	segdisp_slave segdisp0 (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.bus      (seg_bus.slv),
		.seg0_o   (segdisp0_o),
		.seg1_o   (segdisp1_o)
	);

	// interrupt goes straight out, no cpu here
	timer_slave timer0 (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.bus      (tmr_bus.slv),
		.int_o    (timer_int_o)
	);

endmodule

// File: logic/timer_slave.sv
`include "sopc_cfg.svh"

module timer_slave (
	input  logic clk,
	input  logic arst_n_i,
	wb_if.slv    bus,
	output logic int_o
);

	sopc_pkg::tmr_reg_e  reg_sel;
	logic                acc;
	logic                wr;
	logic                ack_q;
	logic                en_q;
	logic                flag_q;
	logic                hit;
	logic [`SOPC_DW-1:0] cmp_q;
	logic [`SOPC_DW-1:0] cnt_q;
	logic [`SOPC_DW-1:0] rdata_q;

	assign reg_sel = sopc_pkg::tmr_reg_e'(bus.adr[3:2]);
	assign acc     = bus.cyc && bus.stb && !ack_q;
	assign wr      = acc && bus.we;
	assign hit     = en_q && (cnt_q == cmp_q);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q  <= 1'b0;
			en_q   <= 1'b0;
			cmp_q  <= '0;
			cnt_q  <= '0;
			flag_q <= 1'b0;
		end else begin
			ack_q <= acc;
			if (wr && reg_sel == sopc_pkg::TMR_CTRL) begin
				en_q <= bus.dat_w[0];
			end
			if (wr && reg_sel == sopc_pkg::TMR_CMP) begin
				cmp_q <= bus.dat_w;
			end
			// counter holds while disabled
			if (hit) begin
				cnt_q <= '0;
			end else if (en_q) begin
				cnt_q <= cnt_q + 1'b1;
			end
			// a new match wins over a clear in the same cycle
			if (hit) begin
				flag_q <= 1'b1;
			end else if (wr && reg_sel == sopc_pkg::TMR_STAT && bus.dat_w[0]) begin
				flag_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (acc) begin
			case (reg_sel)
				sopc_pkg::TMR_CTRL: rdata_q <= {{(`SOPC_DW-1){1'b0}}, en_q};
				sopc_pkg::TMR_CMP:  rdata_q <= cmp_q;
				sopc_pkg::TMR_CNT:  rdata_q <= cnt_q;
				default:            rdata_q <= {{(`SOPC_DW-1){1'b0}}, flag_q};
			endcase
		end
	end

	assign int_o     = flag_q;
	assign bus.ack   = ack_q;
	assign bus.dat_r = rdata_q;

	a_tmr_ack_single: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		ack_q |=> !ack_q
	);

endmodule

// File: logic/segdisp_slave.sv
`include "sopc_cfg.svh"

module segdisp_slave (
	input  logic       clk,
	input  logic       arst_n_i,
	wb_if.slv          bus,
	output logic [6:0] seg0_o,
	output logic [6:0] seg1_o
);

	logic                acc;
	logic                at_reg;
	logic                ack_q;
	logic                shown_q;
	logic [7:0]          disp_q;
	logic [`SOPC_DW-1:0] rdata_q;

	// hex digit to segments, bit 6 is a, bit 0 is g
	function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
		case (nib)
			4'h0: hex_to_seg = 7'h7e;
			4'h1: hex_to_seg = 7'h30;
			4'h2: hex_to_seg = 7'h6d;
			4'h3: hex_to_seg = 7'h79;
			4'h4: hex_to_seg = 7'h33;
			4'h5: hex_to_seg = 7'h5b;
			4'h6: hex_to_seg = 7'h5f;
			4'h7: hex_to_seg = 7'h70;
			4'h8: hex_to_seg = 7'h7f;
			4'h9: hex_to_seg = 7'h7b;
			4'ha: hex_to_seg = 7'h77;
			4'hb: hex_to_seg = 7'h1f;
			4'hc: hex_to_seg = 7'h4e;
			4'hd: hex_to_seg = 7'h3d;
			4'he: hex_to_seg = 7'h4f;
			default: hex_to_seg = 7'h47;
		endcase
	endfunction

	assign acc    = bus.cyc && bus.stb && !ack_q;
	assign at_reg = (bus.adr[3:2] == 2'd0);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q   <= 1'b0;
			shown_q <= 1'b0;
		end else begin
			ack_q <= acc;
			if (acc && bus.we && bus.sel[0] && at_reg) begin
				shown_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (acc && bus.we && bus.sel[0] && at_reg) begin
			disp_q <= bus.dat_w[7:0];
		end
		if (acc) begin
			rdata_q <= at_reg ? {{(`SOPC_DW-8){1'b0}}, disp_q} : '0;
		end
	end

	// blank until the first write
	assign seg0_o = shown_q ? hex_to_seg(disp_q[3:0]) : 7'h00;
	assign seg1_o = shown_q ? hex_to_seg(disp_q[7:4]) : 7'h00;

	assign bus.ack   = ack_q;
	assign bus.dat_r = rdata_q;

	a_seg_ack_single: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		ack_q |=> !ack_q
	);

endmodule

// File: logic/ram_slave.sv
`include "sopc_cfg.svh"

module ram_slave (
	input  logic clk,
	wb_if.slv    bus
);

	localparam int IDX_W = $clog2(`RAM_WORDS);

	logic [`SOPC_DW-1:0] mem [0:`RAM_WORDS-1];
	logic [IDX_W-1:0]    idx;
	logic                acc;
	logic                ack_q;
	logic [`SOPC_DW-1:0] rdata_q;

	// word index from adr[9:2]
	assign idx = bus.adr[IDX_W+1:2];
	assign acc = bus.cyc && bus.stb && !ack_q;

	// ack clears itself once the strobe is gone
	always_ff @(posedge clk) begin
		ack_q <= acc;
	end

	always_ff @(posedge clk) begin
		if (acc && bus.we) begin
			for (int b = 0; b < `SOPC_SELW; b++) begin
				if (bus.sel[b]) begin
					mem[idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
				end
			end
		end
	end

	// old word, whole, in the ack cycle
	always_ff @(posedge clk) begin
		if (acc) begin
			rdata_q <= mem[idx];
		end
	end

	assign bus.ack   = ack_q;
	assign bus.dat_r = rdata_q;

	a_ram_ack_single: assert property (
		@(posedge clk)
		ack_q |=> !ack_q
	);

endmodule

// File: logic/bus_decoder.sv
`include "sopc_cfg.svh"

module bus_decoder (
	input  logic                   clk,
	input  logic                   arst_n_i,

	input  logic                   cyc_i,
	input  logic                   stb_i,
	input  logic                   we_i,
	input  logic [`SOPC_SELW-1:0]  sel_i,
	input  logic [`SOPC_AW-1:0]    adr_i,
	input  logic [`SOPC_DW-1:0]    dat_w_i,
	output logic [`SOPC_DW-1:0]    dat_r_o,
	output logic                   ack_o,

	wb_if.mst                      ram_bus,
	wb_if.mst                      seg_bus,
	wb_if.mst                      tmr_bus
);

	sopc_pkg::slave_e target;
	logic             none_ack_q;

	// region lives in adr[15:12]
	always_comb begin
		case (adr_i[15:12])
			`REGION_RAM: target = sopc_pkg::SLV_RAM;
			`REGION_SEG: target = sopc_pkg::SLV_SEG;
			`REGION_TMR: target = sopc_pkg::SLV_TMR;
			default:     target = sopc_pkg::SLV_NONE;
		endcase
	end

	// shared request lines, strobe to one slave only
	assign ram_bus.cyc   = cyc_i;
	assign ram_bus.stb   = stb_i && (target == sopc_pkg::SLV_RAM);
	assign ram_bus.we    = we_i;
	assign ram_bus.sel   = sel_i;
	assign ram_bus.adr   = adr_i;
	assign ram_bus.dat_w = dat_w_i;

	assign seg_bus.cyc   = cyc_i;
	assign seg_bus.stb   = stb_i && (target == sopc_pkg::SLV_SEG);
	assign seg_bus.we    = we_i;
	assign seg_bus.sel   = sel_i;
	assign seg_bus.adr   = adr_i;
	assign seg_bus.dat_w = dat_w_i;

	assign tmr_bus.cyc   = cyc_i;
	assign tmr_bus.stb   = stb_i && (target == sopc_pkg::SLV_TMR);
	assign tmr_bus.we    = we_i;
	assign tmr_bus.sel   = sel_i;
	assign tmr_bus.adr   = adr_i;
	assign tmr_bus.dat_w = dat_w_i;

	// unmapped accesses get a one-cycle ack, nothing stored
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			none_ack_q <= 1'b0;
		end else begin
			none_ack_q <= cyc_i && stb_i && (target == sopc_pkg::SLV_NONE) && !none_ack_q;
		end
	end

	always_comb begin
		case (target)
			sopc_pkg::SLV_RAM: begin
				dat_r_o = ram_bus.dat_r;
				ack_o   = ram_bus.ack;
			end
			sopc_pkg::SLV_SEG: begin
				dat_r_o = seg_bus.dat_r;
				ack_o   = seg_bus.ack;
			end
			sopc_pkg::SLV_TMR: begin
				dat_r_o = tmr_bus.dat_r;
				ack_o   = tmr_bus.ack;
			end
			default: begin
				dat_r_o = '0;
				ack_o   = none_ack_q;
			end
		endcase
	end

	// no slave answers outside a live cycle
	a_ack_in_cycle: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		ack_o |-> (cyc_i && stb_i)
	);

endmodule

// File: logic/wb_if.sv
`include "sopc_cfg.svh"

interface wb_if;

	logic                   cyc;
	logic                   stb;
	logic                   we;
	logic [`SOPC_SELW-1:0]  sel;
	logic [`SOPC_AW-1:0]    adr;
	logic [`SOPC_DW-1:0]    dat_w;
	logic [`SOPC_DW-1:0]    dat_r;
	logic                   ack;

	// decoder side
	modport mst (
		output cyc, stb, we, sel, adr, dat_w,
		input  dat_r, ack
	);

	// slave side
	modport slv (
		input  cyc, stb, we, sel, adr, dat_w,
		output dat_r, ack
	);

endinterface

// File: logic/sopc_pkg.sv
package sopc_pkg;

	// decoded bus target
	typedef enum logic [1:0] {
		SLV_RAM  = 2'd0,
		SLV_SEG  = 2'd1,
		SLV_TMR  = 2'd2,
		SLV_NONE = 2'd3
	} slave_e;

	// timer register word offsets, adr[3:2]
	typedef enum logic [1:0] {
		TMR_CTRL = 2'd0,
		TMR_CMP  = 2'd1,
		TMR_CNT  = 2'd2,
		TMR_STAT = 2'd3
	} tmr_reg_e;

endpackage

// File: logic/sopc_cfg.svh
`ifndef SOPC_CFG_SVH
`define SOPC_CFG_SVH

// bus widths
`define SOPC_DW    32
`define SOPC_AW    32
`define SOPC_SELW  4

// on-chip ram depth in words
`define RAM_WORDS  256

// values of adr[15:12] per slave
`define REGION_RAM 4'd0
`define REGION_SEG 4'd1
`define REGION_TMR 4'd2

`endif
